// ==== Makefile ====
# Verilator build and run of the MAC parser testbench
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := mac_parser_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+logic
logic/mac_parser_pkg.sv
logic/beat_counter.sv
logic/parse_fsm.sv
logic/field_capture.sv
logic/mac_acl.sv
logic/mac_parser_top.sv
verification/mac_parser_sva.sv
verification/mac_parser_tb.sv

// ==== logic/beat_counter.sv ====
`default_nettype none

`include "mac_parser_consts.svh"

module beat_counter (
    input  wire logic                 aclk,
    input  wire logic                 rst_n,
    // Beat handed on this cycle
    input  wire logic                 beat_accept,
    input  wire logic                 last,
    // Byte offset of the beat now on the bus
    output mac_parser_pkg::pos_t      pos,
    output logic                      first_beat
);

    import mac_parser_pkg::*;

    // Step and ceiling in counter width
    localparam pos_t POS_STEP = pos_t'(`BUS_BYTES);
    localparam pos_t POS_MAX  = pos_t'(`MAX_PACKET_LENGTH);

    // Running byte offset, shared by every field extractor
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (beat_accept) begin
            if (last) begin
                // Next beat opens a new packet
                pos <= '0;
            end else if (pos > POS_MAX - POS_STEP) begin
                // Oversize frame, hold at the ceiling
                pos <= POS_MAX;
            end else begin
                pos <= pos + POS_STEP;
            end
        end
    end

    // Start of packet marker
    assign first_beat = (pos == '0);

endmodule

`default_nettype wire

// ==== logic/field_capture.sv ====
`default_nettype none

`include "mac_parser_consts.svh"

module field_capture #(
    parameter type         field_t = logic [15:0],
    // First byte of the field within the packet
    parameter int unsigned offset  = 0
) (
    input  wire logic                   aclk,
    input  wire logic                   rst_n,
    // Accepted beat of a packet under parse
    input  wire logic                   parse_beat,
    // Accepted last beat of the packet
    input  wire logic                   last,
    input  mac_parser_pkg::pos_t        pos,
    input  wire logic [`BUS_WIDTH-1:0]  tdata,
    output field_t                      field,
    output logic                        complete
);

    import mac_parser_pkg::*;

    localparam int FIELD_BYTES = $bits(field_t) / 8;

    // Bytes held from earlier beats
    logic [FIELD_BYTES-1:0][7:0] stored_bytes;
    logic [FIELD_BYTES-1:0]      stored_valid;

    // Bytes present in the current beat
    logic [FIELD_BYTES-1:0][7:0] cur_bytes;
    logic [FIELD_BYTES-1:0]      cur_hit;

    // Merge of both, current beat wins
    logic [FIELD_BYTES-1:0][7:0] merged_bytes;
    logic [FIELD_BYTES-1:0]      merged_valid;

    for (genvar i = 0; i < FIELD_BYTES; i++) begin : g_byte
        // Beat start offset and lane for this byte, fixed at elaboration
        localparam int   BYTE_POS  = offset + i;
        localparam int   BYTE_LANE = BYTE_POS % `BUS_BYTES;
        localparam pos_t BEAT_POS  = pos_t'(BYTE_POS - BYTE_LANE);

        assign cur_hit[i]   = parse_beat && (pos == BEAT_POS);
        assign cur_bytes[i] = tdata[BYTE_LANE*8 +: 8];

        assign merged_bytes[i] = cur_hit[i] ? cur_bytes[i] : stored_bytes[i];

        // Payload only, validity tracked separately
        always_ff @(posedge aclk) begin
            if (cur_hit[i]) begin
                stored_bytes[i] <= cur_bytes[i];
            end
        end
    end

    assign merged_valid = stored_valid | cur_hit;

    // Byte-valid mask, cleared between packets
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            stored_valid <= '0;
        end else if (last) begin
            stored_valid <= '0;
        end else begin
            stored_valid <= merged_valid;
        end
    end

    // Field usable once every byte has arrived
    assign field    = field_t'(merged_bytes);
    assign complete = &merged_valid;

endmodule

`default_nettype wire

// ==== logic/mac_acl.sv ====
`default_nettype none

`include "mac_parser_consts.svh"

module mac_acl (
    input  wire logic                    aclk,
    input  wire logic                    rst_n,
    input  wire logic                    beat_accept,
    input  wire logic                    last,
    input  mac_parser_pkg::mac_acl_cfg_t cfg,
    // Extracted header fields
    input  mac_parser_pkg::mac_addr_t    da,
    input  mac_parser_pkg::mac_addr_t    sa,
    input  mac_parser_pkg::etype_t       et,
    input  wire logic                    da_complete,
    input  wire logic                    sa_complete,
    input  wire logic                    et_complete,
    output logic                         poisoned,
    output logic                         next_is_ctag_vlan,
    output logic                         dest_is_bc,
    output logic                         dest_is_mc
);

    import mac_parser_pkg::*;

    localparam etype_t CTAG = `ETYPE_CTAG;

    logic da_violation;
    logic sa_violation;
    logic next_violation;
    logic any_violation;
    logic poison_q;

    // Address checks, only once the whole address is in
    assign da_violation = cfg.match_dest && da_complete && (da != cfg.dest_address);
    assign sa_violation = cfg.match_src && sa_complete && (sa != cfg.src_address);

    // Next header type
    assign next_is_ctag_vlan = et_complete && (et == CTAG);

    // C-tag behind the MAC header only if allowed
    assign next_violation = next_is_ctag_vlan && !cfg.allow_next_ctag;

    assign any_violation = da_violation || sa_violation || next_violation;

    // Sticky verdict for the rest of the packet
    // Cleared by the accepted last beat, which wins over a new set
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            poison_q <= 1'b0;
        end else if (beat_accept && last) begin
            poison_q <= 1'b0;
        end else if (any_violation) begin
            poison_q <= 1'b1;
        end
    end

    // Current violations show up without a cycle of delay
    assign poisoned = any_violation || poison_q;

    // Destination class
    // All ones is broadcast
    assign dest_is_bc = da_complete && (&da);
    // Group bit is bit 0 of the first byte on the wire
    assign dest_is_mc = da_complete && da[0];

endmodule

`default_nettype wire

// ==== logic/mac_parser_consts.svh ====
`ifndef MAC_PARSER_CONSTS_SVH
`define MAC_PARSER_CONSTS_SVH

// Stream geometry
// Bytes carried by one beat
`define BUS_BYTES 8
// Data width in bits, always whole bytes
`define BUS_WIDTH (`BUS_BYTES * 8)

// Header field positions
// First byte of each field, counted from the start of the packet
`define DA_OFFSET 0
`define SA_OFFSET 6
`define ET_OFFSET 12

// Packet length limit
// Position counter stops here on oversize frames
`define MAX_PACKET_LENGTH 1522
// Enough bits to hold the limit above
`define POS_BITS 11

// Ethertype codes
// Stored in lane order, first byte on the wire in the low bits
// So 0x8100 on the wire reads back as 0x0081
`define ETYPE_CTAG 16'h0081

`endif

// ==== logic/mac_parser_pkg.sv ====
`default_nettype none

`include "mac_parser_consts.svh"

package mac_parser_pkg;

    // One beat of the byte-lane stream
    // Byte 0 of the beat sits in tdata[7:0]
    typedef struct packed {
        logic [`BUS_WIDTH-1:0] tdata;
        logic [`BUS_BYTES-1:0] tkeep;
        logic                  tlast;
    } axis_beat_t;

    // Header fields, byte 0 in the low bits
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] etype_t;

    // Byte offset within a packet
    typedef logic [`POS_BITS-1:0] pos_t;

    // Per-packet access rules, held stable for a whole packet
    typedef struct packed {
        logic      skip_parsing;
        logic      allow_next_ctag;
        logic      match_src;
        mac_addr_t src_address;
        logic      match_dest;
        mac_addr_t dest_address;
    } mac_acl_cfg_t;

    // Sideband handed to the next parse stage
    typedef struct packed {
        logic   poisoned;
        logic   parsing_done;
        logic   next_is_ctag_vlan;
        etype_t etype;
        logic   etype_valid;
        logic   dest_is_bc;
        logic   dest_is_mc;
    } parse_result_t;

    // Packet parse phase
    typedef enum logic [1:0] {
        PH_PARSE,
        PH_DONE,
        PH_SKIP
    } parse_phase_t;

endpackage

`default_nettype wire

// ==== logic/mac_parser_top.sv ====
`default_nettype none

`include "mac_parser_consts.svh"

module mac_parser_top (
    input  wire logic                     aclk,
    input  wire logic                     rst_n,
    // Upstream side
    input  mac_parser_pkg::axis_beat_t    in_beat,
    input  wire logic                     in_valid,
    output logic                          in_ready,
    // Downstream side
    output mac_parser_pkg::axis_beat_t    out_beat,
    output logic                          out_valid,
    input  wire logic                     out_ready,
    // Access rules
    input  mac_parser_pkg::mac_acl_cfg_t  cfg,
    // Parse sideband and position
    output mac_parser_pkg::parse_result_t result,
    output mac_parser_pkg::pos_t          cur_pos
);

    import mac_parser_pkg::*;

    logic      beat_accept;
    logic      pkt_end;
    logic      first_beat;
    logic      parse_beat;
    logic      parsing_done;

    mac_addr_t da;
    mac_addr_t sa;
    etype_t    et;
    logic      da_complete;
    logic      sa_complete;
    logic      et_complete;

    logic      poisoned;
    logic      next_is_ctag_vlan;
    logic      dest_is_bc;
    logic      dest_is_mc;

    // Stream goes straight through, zero latency
    assign out_beat  = in_beat;
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    // Handshake strobes
    assign beat_accept = in_valid && out_ready;
    assign pkt_end     = beat_accept && in_beat.tlast;

    // Byte position
    beat_counter i_counter (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .beat_accept(beat_accept),
        .last       (in_beat.tlast),
        .pos        (cur_pos),
        .first_beat (first_beat)
    );

    // Phase FSM, phase itself stays internal
    parse_fsm i_fsm (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .beat_accept (beat_accept),
        .last        (in_beat.tlast),
        .first_beat  (first_beat),
        .skip_req    (cfg.skip_parsing),
        .et_complete (et_complete),
        .phase       (),
        .parse_beat  (parse_beat),
        .parsing_done(parsing_done)
    );

    // Destination, beat 0
    field_capture #(.field_t(mac_addr_t), .offset(`DA_OFFSET)) i_da_capture (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .parse_beat(parse_beat),
        .last      (pkt_end),
        .pos       (cur_pos),
        .tdata     (in_beat.tdata),
        .field     (da),
        .complete  (da_complete)
    );

    // Source, split over beats 0 and 1
    field_capture #(.field_t(mac_addr_t), .offset(`SA_OFFSET)) i_sa_capture (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .parse_beat(parse_beat),
        .last      (pkt_end),
        .pos       (cur_pos),
        .tdata     (in_beat.tdata),
        .field     (sa),
        .complete  (sa_complete)
    );

    // Ethertype, beat 1
    field_capture #(.field_t(etype_t), .offset(`ET_OFFSET)) i_et_capture (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .parse_beat(parse_beat),
        .last      (pkt_end),
        .pos       (cur_pos),
        .tdata     (in_beat.tdata),
        .field     (et),
        .complete  (et_complete)
    );

    // Checks and class flags
    mac_acl i_acl (
        .aclk             (aclk),
        .rst_n            (rst_n),
        .beat_accept      (beat_accept),
        .last             (in_beat.tlast),
        .cfg              (cfg),
        .da               (da),
        .sa               (sa),
        .et               (et),
        .da_complete      (da_complete),
        .sa_complete      (sa_complete),
        .et_complete      (et_complete),
        .poisoned         (poisoned),
        .next_is_ctag_vlan(next_is_ctag_vlan),
        .dest_is_bc       (dest_is_bc),
        .dest_is_mc       (dest_is_mc)
    );

    // Sideband for the next stage
    assign result = '{
        poisoned:          poisoned,
        parsing_done:      parsing_done,
        next_is_ctag_vlan: next_is_ctag_vlan,
        etype:             et,
        etype_valid:       et_complete,
        dest_is_bc:        dest_is_bc,
        dest_is_mc:        dest_is_mc
    };

endmodule

`default_nettype wire

// ==== logic/parse_fsm.sv ====
`default_nettype none

module parse_fsm (
    input  wire logic                    aclk,
    input  wire logic                    rst_n,
    input  wire logic                    beat_accept,
    input  wire logic                    last,
    input  wire logic                    first_beat,
    // Skip request, only looked at on the first beat
    input  wire logic                    skip_req,
    // Ethertype fully seen
    input  wire logic                    et_complete,
    output mac_parser_pkg::parse_phase_t phase,
    // Capture enable for all extractors
    output logic                         parse_beat,
    output logic                         parsing_done
);

    import mac_parser_pkg::*;

    parse_phase_t phase_next;
    logic         skip_hit;

    // Skip decision latched once per packet
    assign skip_hit = beat_accept && first_beat && skip_req;

    // Only accepted beats of a packet still under parse get captured
    assign parse_beat = beat_accept && (phase == PH_PARSE) && !skip_hit;

    always_comb begin
        phase_next = phase;
        if (beat_accept && last) begin
            // End of packet, also covers runts that never reach the ethertype
            phase_next = PH_PARSE;
        end else if (phase == PH_PARSE) begin
            if (skip_hit) begin
                phase_next = PH_SKIP;
            end else if (et_complete) begin
                phase_next = PH_DONE;
            end
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_PARSE;
        end else begin
            phase <= phase_next;
        end
    end

    // Done is flagged in the same beat that finishes the header
    // Registered phase keeps it up until the last beat goes
    assign parsing_done = (phase == PH_DONE)
                       || (phase == PH_SKIP)
                       || et_complete
                       || skip_hit;

endmodule

`default_nettype wire

// ==== verification/mac_parser_sva.sv ====
`default_nettype none

module mac_parser_sva (
    input  wire logic                     aclk,
    input  wire logic                     rst_n,
    input  mac_parser_pkg::axis_beat_t    in_beat,
    input  wire logic                     in_valid,
    input  wire logic                     in_ready,
    input  mac_parser_pkg::axis_beat_t    out_beat,
    input  wire logic                     out_valid,
    input  wire logic                     out_ready,
    input  mac_parser_pkg::parse_result_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    // Beat goes through untouched in the same cycle
    a_beat_through: assert property (@(posedge aclk) disable iff (!rst_n)
        out_beat == in_beat)
        else $error("out_beat differs from in_beat");

    a_valid_through: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid == in_valid)
        else $error("out_valid differs from in_valid");

    // Back-pressure passed straight upstream
    a_ready_through: assert property (@(posedge aclk) disable iff (!rst_n)
        in_ready == out_ready)
        else $error("in_ready differs from out_ready");

    // No stale verdict right after reset
    a_clean_after_reset: assert property (@(posedge aclk)
        $rose(rst_n) |-> (!result.poisoned && !result.parsing_done))
        else $error("poisoned or parsing_done high in the first cycle after reset");

endmodule

`default_nettype wire

// ==== verification/mac_parser_tb.sv ====
`default_nettype none

`include "mac_parser_consts.svh"

module mac_parser_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mac_parser_pkg::*;

    localparam int NUM_PACKETS = 40;
    localparam int MAX_BEATS   = 6;
    // Every beat stalled up to a few times plus idle gaps
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * MAX_BEATS * 4 + 1040;
    localparam logic [31:0] SEED = 32'he47c0cb3;
    localparam etype_t CTAG = `ETYPE_CTAG;

    logic          aclk;
    logic          rst_n;
    axis_beat_t    in_beat;
    logic          in_valid;
    logic          in_ready;
    axis_beat_t    out_beat;
    logic          out_valid;
    logic          out_ready;
    mac_acl_cfg_t  cfg;
    parse_result_t result;
    pos_t          cur_pos;

    // Current packet header fields in wire order
    mac_addr_t     pkt_da;
    mac_addr_t     pkt_sa;
    etype_t        pkt_et;
    logic [7:0]    pkt_bytes [MAX_BEATS*`BUS_BYTES];

    // Expected values driven together with the stimulus
    pos_t          exp_pos;
    logic          exp_poisoned;
    logic          exp_done;
    logic          exp_et_valid;
    etype_t        exp_etype;
    logic          exp_ctag;
    logic          exp_bc;
    logic          exp_mc;

    // Stall, skip, poison, ctag, bc, mc seen at least once
    logic [5:0]    reached = '0;
    int            cycle_count = 0;

    mac_parser_top i_dut (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .cfg      (cfg),
        .result   (result),
        .cur_pos  (cur_pos)
    );

    bind mac_parser_top mac_parser_sva i_sva (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .result   (result)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic finish_with_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] got);
        finish_with_failure($sformatf("FAIL time %0t %s expected %0h got %0h",
                                      $time, name, exp, got));
    endtask

    // Expected outputs from the number of beats of this packet seen by the parser
    task automatic update_model(input int acc, input logic take);
        int   seen;
        logic da_done;
        logic hdr_done;
        seen     = take ? acc + 1 : acc;
        // DA lives in beat 0 while SA ends and ET sits in beat 1
        da_done  = !cfg.skip_parsing && (seen >= 1);
        hdr_done = !cfg.skip_parsing && (seen >= 2);
        exp_pos      = pos_t'(acc * `BUS_BYTES);
        exp_et_valid = hdr_done;
        exp_etype    = pkt_et;
        exp_ctag     = hdr_done && (pkt_et == CTAG);
        exp_bc       = da_done && (pkt_da == '1);
        exp_mc       = da_done && pkt_da[0];
        exp_done     = cfg.skip_parsing ? (seen >= 1) : hdr_done;
        exp_poisoned = (da_done && cfg.match_dest && (pkt_da != cfg.dest_address))
                    || (hdr_done && cfg.match_src && (pkt_sa != cfg.src_address))
                    || (exp_ctag && !cfg.allow_next_ctag);
    endtask

    // New rules and header with the odd special case forced
    task automatic pick_packet();
        cfg.skip_parsing    = ($urandom % 6) == 0;
        cfg.allow_next_ctag = 1'($urandom);
        cfg.match_src       = 1'($urandom);
        cfg.match_dest      = 1'($urandom);
        cfg.src_address     = {16'($urandom), $urandom};
        cfg.dest_address    = {16'($urandom), $urandom};
        pkt_da = {16'($urandom), $urandom};
        pkt_sa = {16'($urandom), $urandom};
        pkt_et = 16'($urandom);
        case ($urandom % 5)
            0: pkt_da = cfg.dest_address;
            1: pkt_da = '1;
            2: pkt_da[0] = 1'b1;
            default: pkt_da[0] = 1'b0;
        endcase
        if (($urandom % 2) == 0) begin
            pkt_sa = cfg.src_address;
        end
        if (($urandom % 3) == 0) begin
            pkt_et = CTAG;
        end
        for (int i = 0; i < MAX_BEATS * `BUS_BYTES; i++) begin
            pkt_bytes[i] = 8'($urandom);
        end
        for (int i = 0; i < 6; i++) begin
            pkt_bytes[`DA_OFFSET + i] = pkt_da[8*i +: 8];
            pkt_bytes[`SA_OFFSET + i] = pkt_sa[8*i +: 8];
        end
        pkt_bytes[`ET_OFFSET]     = pkt_et[7:0];
        pkt_bytes[`ET_OFFSET + 1] = pkt_et[15:8];
    endtask

    // Byte j of the beat on lane j
    function automatic logic [`BUS_WIDTH-1:0] beat_data(input int beat);
        logic [`BUS_WIDTH-1:0] data;
        for (int j = 0; j < `BUS_BYTES; j++) begin
            data[8*j +: 8] = pkt_bytes[beat*`BUS_BYTES + j];
        end
        return data;
    endfunction

    // Valid low with junk lanes that must not be taken
    task automatic idle_cycles(input int n);
        repeat (n) begin
            in_valid      = 1'b0;
            out_ready     = 1'($urandom);
            in_beat.tdata = {$urandom, $urandom};
            in_beat.tlast = 1'($urandom);
            update_model(0, 1'b0);
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic send_packet(input int n_beats);
        int   acc;
        logic take;
        logic hold;
        acc  = 0;
        hold = 1'b0;
        while (acc < n_beats) begin
            out_ready     = ($urandom % 4) != 0;
            // Once offered a beat stays until taken
            in_valid      = hold || (($urandom % 4) != 0);
            in_beat.tkeep = '1;
            if (in_valid) begin
                in_beat.tdata = beat_data(acc);
                in_beat.tlast = (acc == n_beats - 1);
            end else begin
                in_beat.tdata = {$urandom, $urandom};
                in_beat.tlast = 1'($urandom);
            end
            take = in_valid && out_ready;
            hold = in_valid && !take;
            update_model(acc, take);
            @(posedge aclk);
            #1;
            if (take) begin
                acc++;
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        in_beat   = '0;
        cfg       = '0;
        pkt_da    = '0;
        pkt_sa    = '0;
        pkt_et    = '0;
        update_model(0, 1'b0);
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        // One quiet cycle out of reset
        @(posedge aclk);
        #1;
        for (int p = 0; p < NUM_PACKETS; p++) begin
            pick_packet();
            idle_cycles(int'($urandom % 3));
            send_packet(2 + int'($urandom % 5));
        end
        idle_cycles(2);
        if (reached != '1) begin
            finish_with_failure($sformatf("stimulus missed a case, reach mask %b", reached));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    // Run limit and case tracking
    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            finish_with_failure("timeout, the packet stimulus never finished");
        end else begin
            reached[0] |= in_valid && !out_ready;
            reached[1] |= cfg.skip_parsing && exp_done;
            reached[2] |= exp_poisoned;
            reached[3] |= exp_ctag;
            reached[4] |= exp_bc;
            reached[5] |= exp_mc && !exp_bc;
        end
    end

    // Zero-latency pass-through
    a_beat: assert property (@(posedge aclk) disable iff (!rst_n) out_beat == in_beat)
        else report_mismatch("out_beat", 128'(in_beat), 128'(out_beat));
    a_valid: assert property (@(posedge aclk) disable iff (!rst_n) out_valid == in_valid)
        else report_mismatch("out_valid", 128'(in_valid), 128'(out_valid));
    a_ready: assert property (@(posedge aclk) disable iff (!rst_n) in_ready == out_ready)
        else report_mismatch("in_ready", 128'(out_ready), 128'(in_ready));
    a_pos: assert property (@(posedge aclk) disable iff (!rst_n) cur_pos == exp_pos)
        else report_mismatch("cur_pos", 128'(exp_pos), 128'($sampled(cur_pos)));

    // Parse results against the model
    a_poisoned: assert property (@(posedge aclk) disable iff (!rst_n)
        result.poisoned == exp_poisoned)
        else report_mismatch("result.poisoned", 128'(exp_poisoned),
                             128'($sampled(result.poisoned)));
    a_done: assert property (@(posedge aclk) disable iff (!rst_n)
        result.parsing_done == exp_done)
        else report_mismatch("result.parsing_done", 128'(exp_done),
                             128'($sampled(result.parsing_done)));
    a_et_valid: assert property (@(posedge aclk) disable iff (!rst_n)
        result.etype_valid == exp_et_valid)
        else report_mismatch("result.etype_valid", 128'(exp_et_valid),
                             128'($sampled(result.etype_valid)));
    // Value only meaningful once valid
    a_etype: assert property (@(posedge aclk) disable iff (!rst_n)
        !exp_et_valid || (result.etype == exp_etype))
        else report_mismatch("result.etype", 128'(exp_etype),
                             128'($sampled(result.etype)));
    a_ctag: assert property (@(posedge aclk) disable iff (!rst_n)
        result.next_is_ctag_vlan == exp_ctag)
        else report_mismatch("result.next_is_ctag_vlan", 128'(exp_ctag),
                             128'($sampled(result.next_is_ctag_vlan)));
    a_bc: assert property (@(posedge aclk) disable iff (!rst_n)
        result.dest_is_bc == exp_bc)
        else report_mismatch("result.dest_is_bc", 128'(exp_bc),
                             128'($sampled(result.dest_is_bc)));
    a_mc: assert property (@(posedge aclk) disable iff (!rst_n)
        result.dest_is_mc == exp_mc)
        else report_mismatch("result.dest_is_mc", 128'(exp_mc),
                             128'($sampled(result.dest_is_mc)));

endmodule

`default_nettype wire
